//--- build.f
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/divUnit.sv
hdl/datapath.sv
hdl/mipsCore.sv
tb/mipsCore_sva.sv
tb/mipsCore_tb.sv

//--- Makefile
TOP = mipsCore_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

//--- tb/mipsCore_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module mipsCore_tb;

	logic            clk = 1'b0;
	logic            rst;
	isaPkg::word_t   pcF;
	isaPkg::word_t   instrF;
	isaPkg::word_t   dataAddr;
	isaPkg::word_t   dataWdata;
	logic            dataWe;
	isaPkg::word_t   dataRdata;
	pipePkg::trace_t trace;

	// program and expected trace tables
	isaPkg::word_t   prog [$];
	isaPkg::word_t   expPc [$];
	isaPkg::regIdx_t expNum [$];
	isaPkg::word_t   expData [$];

	// memory model and reference state
	isaPkg::word_t dataMem [64];
	isaPkg::word_t refMem [64];
	isaPkg::word_t refReg [32];
	isaPkg::word_t refHi;
	isaPkg::word_t refLo;

	isaPkg::word_t rngState;
	int            seen;
	int            cycles;
	int            cycleLimit;

	mipsCore mipsCore_inst (
		.clk       (clk),
		.rst       (rst),
		.pcF       (pcF),
		.instrF    (instrF),
		.dataAddr  (dataAddr),
		.dataWdata (dataWdata),
		.dataWe    (dataWe),
		.dataRdata (dataRdata),
		.trace     (trace)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	function automatic isaPkg::word_t xorshift(isaPkg::word_t x);
		isaPkg::word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic failRun();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkWord(string name, isaPkg::word_t exp, isaPkg::word_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			failRun();
		end
	endtask

	task automatic checkReg(string name, isaPkg::regIdx_t exp, isaPkg::regIdx_t act);
		if (exp !== act) begin
			$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
			failRun();
		end
	endtask

	task automatic checkEnable(string name, logic [3:0] exp, logic [3:0] act);
		if (exp !== act) begin
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
			failRun();
		end
	endtask

	// program builders
	// next word lands at index prog.size()
	task automatic emitR(isaPkg::funct_e fn, int rd, int rs, int rt);
		prog.push_back({6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn});
	endtask

	task automatic emitI(isaPkg::opcode_e op, int rt, int rs, int imm);
		prog.push_back({op, 5'(rs), 5'(rt), 16'(imm)});
	endtask

	// offset counts from the delay slot
	task automatic emitBranch(isaPkg::opcode_e op, int rs, int rt, int tgt);
		emitI(op, rt, rs, tgt - prog.size() - 1);
	endtask

	task automatic emitJump(int tgt);
		isaPkg::word_t addr;
		addr = `RESET_PC + 32'(tgt * 4);
		prog.push_back({isaPkg::OP_J, addr[27:2]});
	endtask

	task automatic fillMemory();
		for (int i = 0; i < 64; i++) begin
			rngState   = xorshift(rngState);
			dataMem[i] = rngState;
			refMem[i]  = rngState;
		end
	endtask

	task automatic buildProgram();
		isaPkg::word_t rA;
		isaPkg::word_t rB;
		rngState = xorshift(rngState);
		rA       = rngState;
		rngState = xorshift(rngState);
		rB       = rngState & 32'h7FFF;
		// dependent alu chain at idx 0..10
		emitI(isaPkg::OP_ADDIU, 1, 0, 5);
		emitI(isaPkg::OP_ADDIU, 2, 1, 7);
		emitR(isaPkg::FN_ADDU, 3, 1, 2);
		emitR(isaPkg::FN_SUBU, 4, 3, 1);
		emitR(isaPkg::FN_AND, 5, 4, 3);
		emitR(isaPkg::FN_OR, 6, 5, 2);
		emitR(isaPkg::FN_SLT, 7, 4, 3);
		emitI(isaPkg::OP_LUI, 8, 0, 16'h1234);
		emitR(isaPkg::FN_OR, 8, 8, 6);
		emitI(isaPkg::OP_ADDIU, 9, 0, -8);
		emitR(isaPkg::FN_SLT, 10, 9, 1);
		// load use then store and load back at idx 11..15
		emitI(isaPkg::OP_LW, 11, 0, 8);
		emitR(isaPkg::FN_ADDU, 12, 11, 1);
		emitI(isaPkg::OP_SW, 12, 0, 16);
		emitI(isaPkg::OP_LW, 13, 0, 16);
		emitR(isaPkg::FN_ADDU, 14, 13, 0);
		// beq taken on a fresh operand at idx 16..19
		emitI(isaPkg::OP_ADDIU, 15, 0, 5);
		emitBranch(isaPkg::OP_BEQ, 15, 1, 20);
		emitI(isaPkg::OP_ADDIU, 16, 0, 1);
		emitI(isaPkg::OP_ADDIU, 17, 0, 99);
		// bne right after a load at idx 20..23
		emitI(isaPkg::OP_LW, 18, 0, 0);
		emitBranch(isaPkg::OP_BNE, 18, 0, 24);
		emitR(isaPkg::FN_ADDU, 19, 18, 1);
		emitI(isaPkg::OP_ADDIU, 17, 0, 77);
		// not taken pair at idx 24..27
		emitBranch(isaPkg::OP_BNE, 1, 15, 30);
		emitI(isaPkg::OP_ADDIU, 20, 0, 11);
		emitBranch(isaPkg::OP_BEQ, 1, 2, 30);
		emitI(isaPkg::OP_ADDIU, 21, 0, 22);
		// jump over idx 30
		emitJump(31);
		emitI(isaPkg::OP_ADDIU, 22, 0, 33);
		emitI(isaPkg::OP_ADDIU, 23, 0, 44);
		// divides at idx 31..40
		emitI(isaPkg::OP_LUI, 24, 0, int'(rA[31:16]));
		emitI(isaPkg::OP_ADDIU, 24, 24, int'(rA[15:0]));
		emitI(isaPkg::OP_ADDIU, 25, 0, int'(rB[15:0]));
		emitR(isaPkg::FN_DIVU, 0, 24, 25);
		emitR(isaPkg::FN_MFHI, 26, 0, 0);
		emitR(isaPkg::FN_MFLO, 27, 0, 0);
		// divisor zero
		emitR(isaPkg::FN_DIVU, 0, 24, 0);
		emitR(isaPkg::FN_MFLO, 28, 0, 0);
		emitR(isaPkg::FN_MFHI, 29, 0, 0);
		emitR(isaPkg::FN_ADDU, 30, 28, 29);
		// r0 stays zero at idx 41..43
		emitI(isaPkg::OP_ADDIU, 0, 0, 123);
		emitR(isaPkg::FN_ADDU, 31, 0, 1);
		emitI(isaPkg::OP_SW, 31, 0, 20);
	endtask

	//////////////////////////////////////////////////
	// reference evaluation with one delay slot
	//////////////////////////////////////////////////
	task automatic runReference();
		isaPkg::word_t pc, npc, nnpc, ins, a, b, res, sImm, addr, link;
		isaPkg::regIdx_t dst;
		logic wr;
		int steps;
		pc    = `RESET_PC;
		npc   = pc + 32'd4;
		steps = 0;
		for (int i = 0; i < 32; i++)
			refReg[i] = '0;
		while (((pc - `RESET_PC) >> 2) < 32'(prog.size()) && steps < 1000) begin
			ins  = prog[(pc - `RESET_PC) >> 2];
			nnpc = npc + 32'd4;
			a    = refReg[ins[25:21]];
			b    = refReg[ins[20:16]];
			sImm = {{16{ins[15]}}, ins[15:0]};
			addr = a + sImm;
			link = pc + 32'd4;
			dst  = ins[20:16];
			wr   = 1'b0;
			res  = '0;
			case (ins[31:26])
				isaPkg::OP_SPECIAL: begin
					dst = ins[15:11];
					wr  = 1'b1;
					case (ins[5:0])
						isaPkg::FN_ADDU: res = a + b;
						isaPkg::FN_SUBU: res = a - b;
						isaPkg::FN_AND:  res = a & b;
						isaPkg::FN_OR:   res = a | b;
						isaPkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						isaPkg::FN_MFHI: res = refHi;
						isaPkg::FN_MFLO: res = refLo;
						isaPkg::FN_DIVU: begin
							wr = 1'b0;
							// divide by zero gives all-ones quotient
							if (b == '0) begin
								refLo = '1;
								refHi = a;
							end else begin
								refLo = a / b;
								refHi = a % b;
							end
						end
						default: wr = 1'b0;
					endcase
				end
				isaPkg::OP_ADDIU: begin
					res = a + sImm;
					wr  = 1'b1;
				end
				isaPkg::OP_LUI: begin
					res = {ins[15:0], 16'h0};
					wr  = 1'b1;
				end
				isaPkg::OP_LW: begin
					res = refMem[addr[7:2]];
					wr  = 1'b1;
				end
				isaPkg::OP_SW: refMem[addr[7:2]] = b;
				isaPkg::OP_BEQ: if (a == b) nnpc = link + (sImm << 2);
				isaPkg::OP_BNE: if (a != b) nnpc = link + (sImm << 2);
				isaPkg::OP_J: nnpc = {link[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			// r0 writes are dropped and not traced
			if (wr && dst != '0) begin
				refReg[dst] = res;
				expPc.push_back(pc);
				expNum.push_back(dst);
				expData.push_back(res);
			end
			pc    = npc;
			npc   = nnpc;
			steps = steps + 1;
		end
	endtask

	function automatic isaPkg::word_t fetchWord(isaPkg::word_t a);
		isaPkg::word_t off;
		off = a - `RESET_PC;
		// past the program reads as nop
		if ((off >> 2) < 32'(prog.size()))
			return prog[off >> 2];
		return '0;
	endfunction

	//////////////////////////////////////////////////
	// memory models
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		instrF    = fetchWord(pcF);
		dataRdata = dataMem[dataAddr[7:2]];
	end

	always @(posedge clk) begin
		if (dataWe === 1'b1)
			dataMem[dataAddr[7:2]] <= dataWdata;
	end

	// trace compare in program order
	always @(negedge clk) begin
		if (!rst && trace.wen != 4'b0) begin
			if (seen >= expPc.size()) begin
				$display("DUT wrote register %0d with no write left in the program",
					trace.wnum);
				failRun();
			end
			checkWord($sformatf("trace %0d pc", seen), expPc[seen], trace.pc);
			checkEnable($sformatf("trace %0d wen", seen), 4'b1111, trace.wen);
			checkReg($sformatf("trace %0d wnum", seen), expNum[seen], trace.wnum);
			checkWord($sformatf("trace %0d wdata", seen), expData[seen], trace.wdata);
			seen = seen + 1;
		end
	end

	// hang guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("timeout after %0d cycles with %0d of %0d trace entries seen",
				cycles, seen, expPc.size());
			failRun();
		end
	end

	initial begin
		rst        = 1'b1;
		instrF     = '0;
		dataRdata  = '0;
		seen       = 0;
		cycles     = 0;
		rngState   = 32'd87;
		fillMemory();
		buildProgram();
		runReference();
		cycleLimit = prog.size() * (`DIV_STEPS + 6);
		repeat (4) @(negedge clk);
		rst = 1'b0;
		while (seen < expPc.size())
			@(negedge clk);
		// drain so a late entry trips the monitor
		repeat (10) @(negedge clk);
		for (int i = 0; i < 64; i++)
			checkWord($sformatf("data word %0d", i), refMem[i], dataMem[i]);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/mipsCore_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore_sva (
	input logic            clk,
	input logic            rst,
	input logic            dataWe,
	input isaPkg::word_t   pcF,
	input logic            stallF,
	input pipePkg::trace_t trace
);

	// no store while reset holds
	// first reset cycle skipped, stage regs still settling
	noStoreInReset: assert property (@(posedge clk) rst && $past(rst) |-> !dataWe)
		else $error("data write enable high during reset");

	// r0 writes never reach the trace
	noTraceR0: assert property (@(posedge clk) disable iff (rst)
		(|trace.wen) |-> trace.wnum != '0)
		else $error("trace entry for register 0");

	// fetch pc frozen by a stall
	pcHoldOnStall: assert property (@(posedge clk) disable iff (rst)
		stallF |=> $stable(pcF))
		else $error("pc moved during a fetch stall");

endmodule

bind mipsCore mipsCore_sva mipsCore_sva_inst (
	.clk    (clk),
	.rst    (rst),
	.dataWe (dataWe),
	.pcF    (pcF),
	.stallF (stallF),
	.trace  (trace)
);

`default_nettype wire

//--- hdl/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input  logic            clk, rst,
	output isaPkg::word_t   pcF,
	input  isaPkg::word_t   instrF,
	output isaPkg::word_t   dataAddr, dataWdata,
	output logic            dataWe,
	input  isaPkg::word_t   dataRdata,
	output pipePkg::trace_t trace
);

	// decoder loop
	isaPkg::word_t    instrD;
	pipePkg::ctrl_t   ctrlD;
	// status toward the hazard unit
	isaPkg::regIdx_t  rsD, rtD, rsE, rtE, destE, destM, destW;
	logic             branchD, regWriteE, memReadE, divBusy;
	logic             regWriteM, memReadM, regWriteW;
	// controls back into the datapath
	logic             stallF, stallD, bubbleE;
	pipePkg::fwdSel_e fwdA, fwdB;
	logic             fwdBrA, fwdBrB;

	decoder decoder_inst (
		.instr (instrD),
		.ctrl  (ctrlD)
	);

	// names match port for port
	hazardUnit hazardUnit_inst (.*);

	datapath datapath_inst (.*);

endmodule

`default_nettype wire

//--- hdl/datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module datapath (
	input  logic             clk, rst,
	// instruction port
	output isaPkg::word_t    pcF,
	input  isaPkg::word_t    instrF,
	// data port
	output isaPkg::word_t    dataAddr, dataWdata,
	output logic             dataWe,
	input  isaPkg::word_t    dataRdata,
	// decoder loop
	output isaPkg::word_t    instrD,
	input  pipePkg::ctrl_t   ctrlD,
	// hazard controls
	input  logic             stallF, stallD, bubbleE,
	input  pipePkg::fwdSel_e fwdA, fwdB,
	input  logic             fwdBrA, fwdBrB,
	// hazard status
	output isaPkg::regIdx_t  rsD, rtD, rsE, rtE, destE, destM, destW,
	output logic             branchD, regWriteE, memReadE, divBusy,
	output logic             regWriteM, memReadM, regWriteW,
	output pipePkg::trace_t  trace
);

	pipePkg::ifId_t  ifId;
	pipePkg::idEx_t  idEx;
	pipePkg::exMem_t exMem;
	pipePkg::memWb_t memWb;

	isaPkg::regIdx_t  rdD;
	isaPkg::imm16_t   imm16D;
	isaPkg::jumpIdx_t jIdxD;
	isaPkg::word_t    pcPlus4D, immD, brTarget, jTarget;
	isaPkg::word_t    rdataA, rdataB, brA, brB;
	logic             brTaken;
	isaPkg::word_t    opA, opB, aluB, aluOut;
	isaPkg::word_t    hi, lo, memFwd, wbResult;

	//////////////////////////////////////////////////
	// fetch
	//////////////////////////////////////////////////
	// redirect from decode lands after the delay slot
	always_ff @(posedge clk) begin
		if (rst)
			pcF <= `RESET_PC;
		else if (!stallF)
			pcF <= ctrlD.isJump ? jTarget : brTaken ? brTarget : pcF + 32'd4;
	end

	// reset leaves an all-zero word, decodes as nop
	always_ff @(posedge clk) begin
		if (rst)
			ifId <= '0;
		else if (!stallD)
			ifId <= '{pc: pcF, instr: instrF};
	end

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////
	assign instrD  = ifId.instr;
	assign rsD     = instrD[25:21];
	assign rtD     = instrD[20:16];
	assign rdD     = instrD[15:11];
	assign imm16D  = instrD[15:0];
	assign jIdxD   = instrD[25:0];
	assign branchD = ctrlD.isBranch;

	assign immD     = ctrlD.zeroExt ? {16'b0, imm16D} : {{16{imm16D[15]}}, imm16D};
	assign pcPlus4D = ifId.pc + 32'd4;
	assign brTarget = pcPlus4D + {immD[29:0], 2'b00};
	// region of the delay slot
	assign jTarget  = {pcPlus4D[31:28], jIdxD, 2'b00};

	regFile regFile_inst (
		.clk    (clk),
		.we     (memWb.regWrite),
		.waddr  (memWb.dest),
		.wdata  (wbResult),
		.raddrA (rsD),
		.raddrB (rtD),
		.rdataA (rdataA),
		.rdataB (rdataB)
	);

	// branch compare on forwarded operands
	assign brA     = fwdBrA ? memFwd : rdataA;
	assign brB     = fwdBrB ? memFwd : rdataB;
	assign brTaken = ctrlD.isBranch && ((brA == brB) != ctrlD.branchNe);

	// held while dividing, whole ctrl cleared on a bubble
	always_ff @(posedge clk) begin
		if (rst)
			idEx.ctrl <= '0;
		else if (!divBusy)
			idEx <= '{ctrl: bubbleE ? pipePkg::ctrl_t'('0) : ctrlD, pc: ifId.pc,
				rsVal: rdataA, rtVal: rdataB, imm: immD, rs: rsD, rt: rtD,
				dest: ctrlD.regDstRd ? rdD : rtD};
	end

	//////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////
	function automatic isaPkg::word_t fwdMux(pipePkg::fwdSel_e sel, isaPkg::word_t regVal,
			isaPkg::word_t memVal, isaPkg::word_t wbVal);
		case (sel)
			pipePkg::FWD_MEM: return memVal;
			pipePkg::FWD_WB:  return wbVal;
			default:          return regVal;
		endcase
	endfunction

	assign opA  = fwdMux(fwdA, idEx.rsVal, memFwd, wbResult);
	assign opB  = fwdMux(fwdB, idEx.rtVal, memFwd, wbResult);
	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			isaPkg::ALU_SUB: aluOut = opA - aluB;
			isaPkg::ALU_AND: aluOut = opA & aluB;
			isaPkg::ALU_OR:  aluOut = opA | aluB;
			isaPkg::ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(aluB)};
			isaPkg::ALU_LUI: aluOut = {aluB[15:0], 16'b0};
			default:         aluOut = opA + aluB;
		endcase
	end

	// divu sits in execute until busy drops
	divUnit divUnit_inst (
		.clk      (clk),
		.rst      (rst),
		.start    (idEx.ctrl.startDiv),
		.dividend (opA),
		.divisor  (opB),
		.busy     (divBusy),
		.hi       (hi),
		.lo       (lo)
	);

	assign rsE       = idEx.rs;
	assign rtE       = idEx.rt;
	assign destE     = idEx.dest;
	assign regWriteE = idEx.ctrl.regWrite;
	assign memReadE  = idEx.ctrl.memRead;

	// bubble into memory while the divider runs
	always_ff @(posedge clk) begin
		if (rst || divBusy) begin
			exMem.regWrite <= 1'b0;
			exMem.memRead  <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem <= '{regWrite: idEx.ctrl.regWrite, memRead: idEx.ctrl.memRead,
				memWrite: idEx.ctrl.memWrite, resSel: idEx.ctrl.resSel, pc: idEx.pc,
				aluOut: aluOut, storeVal: opB, dest: idEx.dest};
		end
	end

	//////////////////////////////////////////////////
	// memory
	//////////////////////////////////////////////////
	assign dataAddr  = exMem.aluOut;
	assign dataWdata = exMem.storeVal;
	assign dataWe    = exMem.memWrite;
	assign destM     = exMem.dest;
	assign regWriteM = exMem.regWrite;
	assign memReadM  = exMem.memRead;

	// forwarded value, mfhi/mflo need hi/lo here
	always_comb begin
		case (exMem.resSel)
			pipePkg::RES_HI: memFwd = hi;
			pipePkg::RES_LO: memFwd = lo;
			default:         memFwd = exMem.aluOut;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			memWb.regWrite <= 1'b0;
		else
			memWb <= '{regWrite: exMem.regWrite, resSel: exMem.resSel, pc: exMem.pc,
				aluOut: exMem.aluOut, memData: dataRdata, dest: exMem.dest};
	end

	//////////////////////////////////////////////////
	// writeback
	//////////////////////////////////////////////////
	always_comb begin
		case (memWb.resSel)
			pipePkg::RES_MEM: wbResult = memWb.memData;
			pipePkg::RES_HI:  wbResult = hi;
			pipePkg::RES_LO:  wbResult = lo;
			default:          wbResult = memWb.aluOut;
		endcase
	end

	assign destW     = memWb.dest;
	assign regWriteW = memWb.regWrite;

	// all four byte enables on a gpr write
	assign trace = '{pc: memWb.pc, wen: {4{memWb.regWrite}}, wnum: memWb.dest,
		wdata: wbResult};

endmodule

`default_nettype wire

//--- hdl/divUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module divUnit (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  isaPkg::word_t dividend,
	input  isaPkg::word_t divisor,
	output logic          busy,
	output isaPkg::word_t hi,
	output isaPkg::word_t lo
);

	localparam int CntW = $clog2(`DIV_STEPS);

	pipePkg::divState_e state;
	logic [CntW-1:0]    stepCnt;
	logic               launch;
	logic               lastStep;

	// partial remainder, quotient/dividend shifter, divisor copy
	isaPkg::word_t   rem;
	isaPkg::word_t   quo;
	isaPkg::word_t   dsr;
	logic [`DATA_W:0] partial;
	logic [`DATA_W:0] diff;
	logic             fits;

	assign launch   = state == pipePkg::DIV_IDLE && start;
	assign lastStep = stepCnt == CntW'(`DIV_STEPS - 1);

	// covers the launch cycle too so the divu stays in execute
	// DONE lets it move on while hi/lo update
	assign busy = launch || state == pipePkg::DIV_RUN;

	//////////////////////////////////////////////////
	// FSM and step counter
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= pipePkg::DIV_IDLE;
			stepCnt <= '0;
		end else begin
			case (state)
				pipePkg::DIV_IDLE: begin
					if (start) begin
						state   <= pipePkg::DIV_RUN;
						stepCnt <= '0;
					end
				end
				pipePkg::DIV_RUN: begin
					stepCnt <= stepCnt + 1'b1;
					if (lastStep)
						state <= pipePkg::DIV_DONE;
				end
				default: state <= pipePkg::DIV_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// restoring shift-subtract
	//////////////////////////////////////////////////
	// next dividend bit shifts into the remainder
	assign partial = {rem, quo[`DATA_W-1]};
	assign diff    = partial - {1'b0, dsr};
	// no borrow, keep the difference
	// divisor 0 always fits -> all-ones quotient, rem = dividend
	assign fits    = !diff[`DATA_W];

	always_ff @(posedge clk) begin
		if (launch) begin
			rem <= '0;
			quo <= dividend;
			dsr <= divisor;
		end else if (state == pipePkg::DIV_RUN) begin
			rem <= fits ? diff[`DATA_W-1:0] : partial[`DATA_W-1:0];
			quo <= {quo[`DATA_W-2:0], fits};
		end
		// results visible from the next cycle on
		if (state == pipePkg::DIV_DONE) begin
			hi <= rem;
			lo <= quo;
		end
	end

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	// decode
	input  isaPkg::regIdx_t  rsD, rtD,
	input  logic             branchD,
	// execute
	input  isaPkg::regIdx_t  rsE, rtE, destE,
	input  logic             regWriteE, memReadE, divBusy,
	// memory
	input  isaPkg::regIdx_t  destM,
	input  logic             regWriteM, memReadM,
	// writeback
	input  isaPkg::regIdx_t  destW,
	input  logic             regWriteW,
	output logic             stallF, stallD, bubbleE,
	output pipePkg::fwdSel_e fwdA, fwdB,
	output logic             fwdBrA, fwdBrB
);

	logic loadUse;
	logic brWaitE;
	logic brWaitM;
	logic holdD;

	// regWrite is never set for r0
	// so no zero-index checks below

	// load in execute feeding decode
	assign loadUse = memReadE && regWriteE && (destE == rsD || destE == rtD);
	// branch compare in decode needs final operands
	// producer still in execute
	assign brWaitE = branchD && regWriteE && (destE == rsD || destE == rtD);
	// load still reading memory
	assign brWaitM = branchD && memReadM && regWriteM && (destM == rsD || destM == rtD);
	assign holdD   = loadUse || brWaitE || brWaitM;

	// divider freezes F/D/E, bubbles flow into memory
	assign stallF  = holdD || divBusy;
	assign stallD  = holdD || divBusy;
	// execute is held during a divide, not bubbled
	assign bubbleE = holdD && !divBusy;

	// youngest producer wins, memory before writeback
	function automatic pipePkg::fwdSel_e pickSrc(isaPkg::regIdx_t src);
		if (regWriteM && destM == src)
			return pipePkg::FWD_MEM;
		if (regWriteW && destW == src)
			return pipePkg::FWD_WB;
		return pipePkg::FWD_REG;
	endfunction

	always_comb begin
		fwdA = pickSrc(rsE);
		fwdB = pickSrc(rtE);
	end

	// branch operands
	// writeback is covered by the regfile bypass
	assign fwdBrA = regWriteM && destM == rsD;
	assign fwdBrB = regWriteM && destM == rtD;

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module regFile (
	input  logic            clk,
	input  logic            we,
	input  isaPkg::regIdx_t waddr,
	input  isaPkg::word_t   wdata,
	input  isaPkg::regIdx_t raddrA,
	input  isaPkg::regIdx_t raddrB,
	output isaPkg::word_t   rdataA,
	output isaPkg::word_t   rdataB
);

	isaPkg::word_t regs [2**`REG_AW];

	// writeback port
	always_ff @(posedge clk) begin
		if (we)
			regs[waddr] <= wdata;
	end

	// r0 reads zero
	// same-cycle write goes straight through
	function automatic isaPkg::word_t readReg(isaPkg::regIdx_t idx);
		if (idx == '0)
			return '0;
		if (we && waddr == idx)
			return wdata;
		return regs[idx];
	endfunction

	always_comb begin
		rdataA = readReg(raddrA);
		rdataB = readReg(raddrB);
	end

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  isaPkg::word_t  instr,
	output pipePkg::ctrl_t ctrl
);

	isaPkg::opcode_e op;
	isaPkg::funct_e  fn;

	assign op = isaPkg::opcode_e'(instr[31:26]);
	assign fn = isaPkg::funct_e'(instr[5:0]);

	always_comb begin
		// everything off is a nop
		ctrl = '0;
		case (op)
			isaPkg::OP_SPECIAL: begin
				// R-type writes rd
				ctrl.regDstRd = 1'b1;
				ctrl.regWrite = 1'b1;
				case (fn)
					isaPkg::FN_ADDU: ctrl.aluOp = isaPkg::ALU_ADD;
					isaPkg::FN_SUBU: ctrl.aluOp = isaPkg::ALU_SUB;
					isaPkg::FN_AND:  ctrl.aluOp = isaPkg::ALU_AND;
					isaPkg::FN_OR:   ctrl.aluOp = isaPkg::ALU_OR;
					isaPkg::FN_SLT:  ctrl.aluOp = isaPkg::ALU_SLT;
					isaPkg::FN_MFHI: ctrl.resSel = pipePkg::RES_HI;
					isaPkg::FN_MFLO: ctrl.resSel = pipePkg::RES_LO;
					isaPkg::FN_DIVU: begin
						// result lands in hi/lo, no gpr write
						ctrl.regWrite = 1'b0;
						ctrl.startDiv = 1'b1;
					end
					// sll/nop and the rest
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			isaPkg::OP_ADDIU: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			isaPkg::OP_LUI: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExt   = 1'b1;
				ctrl.aluOp     = isaPkg::ALU_LUI;
			end
			isaPkg::OP_LW: begin
				// address add, data from memory
				ctrl.regWrite  = 1'b1;
				ctrl.memRead   = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.resSel    = pipePkg::RES_MEM;
			end
			isaPkg::OP_SW: begin
				ctrl.memWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			isaPkg::OP_BEQ: ctrl.isBranch = 1'b1;
			isaPkg::OP_BNE: begin
				ctrl.isBranch = 1'b1;
				ctrl.branchNe = 1'b1;
			end
			isaPkg::OP_J: ctrl.isJump = 1'b1;
			default: ;
		endcase
		// r0 is hardwired so its writes vanish here
		if ((ctrl.regDstRd ? instr[15:11] : instr[20:16]) == '0)
			ctrl.regWrite = 1'b0;
	end

endmodule

`default_nettype wire

//--- hdl/pipePkg.sv
`default_nettype none

package pipePkg;

	// writeback result source
	typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_HI, RES_LO} resSel_e;

	// execute operand source
	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSel_e;

	// divider FSM
	typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} divState_e;

	//////////////////////////////////////////////////
	// decode control bundle
	//////////////////////////////////////////////////
	typedef struct packed {
		logic           regWrite;
		logic           memRead;
		logic           memWrite;
		// b operand from immediate
		logic           aluSrcImm;
		// dest is rd, else rt
		logic           regDstRd;
		logic           zeroExt;
		isaPkg::aluOp_e aluOp;
		resSel_e        resSel;
		logic           isBranch;
		// bne, inverts the compare
		logic           branchNe;
		logic           isJump;
		logic           startDiv;
	} ctrl_t;

	//////////////////////////////////////////////////
	// stage registers
	//////////////////////////////////////////////////
	typedef struct packed {
		isaPkg::word_t pc;
		isaPkg::word_t instr;
	} ifId_t;

	typedef struct packed {
		ctrl_t           ctrl;
		isaPkg::word_t   pc;
		isaPkg::word_t   rsVal;
		isaPkg::word_t   rtVal;
		// already extended
		isaPkg::word_t   imm;
		isaPkg::regIdx_t rs;
		isaPkg::regIdx_t rt;
		isaPkg::regIdx_t dest;
	} idEx_t;

	typedef struct packed {
		logic            regWrite;
		logic            memRead;
		logic            memWrite;
		resSel_e         resSel;
		isaPkg::word_t   pc;
		isaPkg::word_t   aluOut;
		isaPkg::word_t   storeVal;
		isaPkg::regIdx_t dest;
	} exMem_t;

	typedef struct packed {
		logic            regWrite;
		resSel_e         resSel;
		isaPkg::word_t   pc;
		isaPkg::word_t   aluOut;
		isaPkg::word_t   memData;
		isaPkg::regIdx_t dest;
	} memWb_t;

	// writeback trace, one entry per gpr write
	typedef struct packed {
		isaPkg::word_t   pc;
		logic [3:0]      wen;
		isaPkg::regIdx_t wnum;
		isaPkg::word_t   wdata;
	} trace_t;

endpackage

`default_nettype wire

//--- hdl/isaPkg.sv
`default_nettype none
`include "mips_params.svh"

package isaPkg;

	// data and instruction word
	typedef logic [`DATA_W-1:0] word_t;
	// gpr number
	typedef logic [`REG_AW-1:0] regIdx_t;

	// immediate field of I-type
	typedef logic [15:0] imm16_t;
	// word index field of J-type
	typedef logic [25:0] jumpIdx_t;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_LUI     = 6'h0F,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2B
	} opcode_e;

	// SPECIAL funct, instr[5:0]
	typedef enum logic [5:0] {
		FN_MFHI = 6'h10,
		FN_MFLO = 6'h12,
		FN_DIVU = 6'h1B,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2A
	} funct_e;

	// execute stage ALU function
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} aluOp_e;

endpackage

`default_nettype wire

//--- hdl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// machine word width
// covers data, instructions and addresses
`define DATA_W 32

// register index width
// 2**REG_AW general purpose registers
`define REG_AW 5

// boot vector in kseg1
`define RESET_PC 32'hBFC00000

// restoring divide steps
// one quotient bit per step
`define DIV_STEPS 32

`endif
